// ==== Bender.yml ====
package:
  name: adc_capture

sources:
  # Packages first, then RTL bottom-up
  - design/adc_sample_pkg.sv
  - design/adc_tap_pkg.sv
  - design/tap_ctrl_decode.sv
  - design/sample_unpack.sv
  - design/adc_capture_top.sv

  # Testbench and bound checkers
  - target: test
    files:
      - test/adc_capture_assertions.sv
      - test/adc_capture_tb.sv

// ==== adc_capture.f ====
design/adc_sample_pkg.sv
design/adc_tap_pkg.sv
design/tap_ctrl_decode.sv
design/sample_unpack.sv
design/adc_capture_top.sv
test/adc_capture_assertions.sv
test/adc_capture_tb.sv

// ==== design/adc_capture_top.sv ====
`timescale 1ns/10ps

module adc_capture_top
    import adc_sample_pkg::*;
    import adc_tap_pkg::*;
#(
    parameter int   NUM_LANES  = 4,                                      // Even lane count
    localparam int  NUM_BITS   = NUM_LANES * LANE_WIDTH,                 // Delay-load strobes
    localparam int  IQ_SAMPLES = (NUM_LANES / 2) * SAMPLES_PER_LANE      // Samples per rail
)
(
    input  logic                                             sys_clk,
    input  logic                                             rst,

    // --------------------
    // Control side
    // --------------------
    input  tap_t                                             dly_val,
    input  bit_sel_t                                         dly_sel,
    input  logic                                             phase_step_req,
    input  logic                                             phase_dir,

    output logic [NUM_BITS-1:0]                              bit_load,
    output tap_t [NUM_LANES-1:0]                             tap_value,
    output logic                                             phase_step,
    output logic                                             phase_dir_out,

    // --------------------
    // Sample side
    // --------------------
    input  lane_word_t [NUM_LANES-1:0][SAMPLES_PER_LANE-1:0] lane_data,
    input  logic                                             lane_valid,
    input  logic                                             lane_sync,

    output sample_data_t [IQ_SAMPLES-1:0]                    data_i,
    output sample_info_t [IQ_SAMPLES-1:0]                    info_i,
    output sample_data_t [IQ_SAMPLES-1:0]                    data_q,
    output sample_info_t [IQ_SAMPLES-1:0]                    info_q,
    output logic                                             sample_valid,
    output logic                                             sample_sync
);

    // Delay and clock-phase control decode
    tap_ctrl_decode #(
        .NUM_LANES      (NUM_LANES)
    ) tap_ctrl_decode_i (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .dly_val        (dly_val),
        .dly_sel        (dly_sel),
        .phase_step_req (phase_step_req),
        .phase_dir      (phase_dir),
        .bit_load       (bit_load),
        .tap_value      (tap_value),
        .phase_step     (phase_step),
        .phase_dir_out  (phase_dir_out)
    );

    // Lane recapture and I/Q ordering, one cycle through
    sample_unpack #(
        .NUM_LANES      (NUM_LANES)
    ) sample_unpack_i (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .lane_data      (lane_data),
        .lane_valid     (lane_valid),
        .lane_sync      (lane_sync),
        .data_i         (data_i),
        .data_q         (data_q),
        .info_i         (info_i),
        .info_q         (info_q),
        .sample_valid   (sample_valid),
        .sample_sync    (sample_sync)
    );

endmodule

// ==== design/adc_sample_pkg.sv ====
package adc_sample_pkg;

    // --------------------
    // Lane word layout
    // --------------------
    localparam int LANE_WIDTH       = 14;  // Raw bits per deserialized lane word
    localparam int DATA_WIDTH       = 12;  // Sample data, word bits 11:0
    localparam int INFO_WIDTH       = 2;   // Info flags, word bits 13:12
    localparam int SAMPLES_PER_LANE = 4;   // Time slots per lane per clock

    // Slot 0 is the oldest sample of the clock

    // --------------------
    // Field types
    // --------------------
    typedef logic [LANE_WIDTH-1:0] lane_word_t;    // One raw lane word
    typedef logic [DATA_WIDTH-1:0] sample_data_t;  // Data field
    typedef logic [INFO_WIDTH-1:0] sample_info_t;  // Info field

    // Data and info together fill the whole word

endpackage

// ==== design/adc_tap_pkg.sv ====
package adc_tap_pkg;

    // --------------------
    // Delay control widths
    // --------------------
    localparam int TAP_WIDTH = 5;  // Input delay tap count, 0..31
    localparam int SEL_WIDTH = 6;  // Code picking one lane bit to load

    // One select code addresses a single lane bit
    // Codes past the last lane bit load nothing

    // --------------------
    // Types
    // --------------------
    typedef logic [TAP_WIDTH-1:0] tap_t;      // Tap value for a delay load
    typedef logic [SEL_WIDTH-1:0] bit_sel_t;  // Bit-select code

endpackage

// ==== design/sample_unpack.sv ====
`timescale 1ns/10ps

module sample_unpack
    import adc_sample_pkg::*;
#(
    parameter int   NUM_LANES  = 4,                                // Must be even
    localparam int  HALF_LANES = NUM_LANES / 2,                    // Lanes per I or Q group
    localparam int  IQ_SAMPLES = HALF_LANES * SAMPLES_PER_LANE     // Samples per rail
)
(
    input  logic                                             sys_clk,
    input  logic                                             rst,

    input  lane_word_t [NUM_LANES-1:0][SAMPLES_PER_LANE-1:0] lane_data,  // [lane][slot]
    input  logic                                             lane_valid,
    input  logic                                             lane_sync,

    output sample_data_t [IQ_SAMPLES-1:0]                    data_i,
    output sample_data_t [IQ_SAMPLES-1:0]                    data_q,
    output sample_info_t [IQ_SAMPLES-1:0]                    info_i,
    output sample_info_t [IQ_SAMPLES-1:0]                    info_q,
    output logic                                             sample_valid,
    output logic                                             sample_sync
);

    lane_word_t [NUM_LANES-1:0][SAMPLES_PER_LANE-1:0] lane_q;  // Recaptured words

    // --------------------
    // Recapture stage
    // --------------------
    // Words and strobes share one stage so they stay aligned
    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            lane_q       <= '0;
            sample_valid <= 1'b0;
            sample_sync  <= 1'b0;
        end
        else
        begin
            lane_q       <= lane_data;
            sample_valid <= lane_valid;
            sample_sync  <= lane_sync;
        end
    end

    // --------------------
    // Field split
    // --------------------
    // Lower lanes carry I, upper lanes carry Q
    // Output index is lane-in-group * SAMPLES_PER_LANE + slot
    always_comb
    begin
        for (int l = 0; l < HALF_LANES; l++)
        begin
            for (int t = 0; t < SAMPLES_PER_LANE; t++)
            begin
                // I rail from lane l
                data_i[l*SAMPLES_PER_LANE + t] = lane_q[l][t][DATA_WIDTH-1:0];
                info_i[l*SAMPLES_PER_LANE + t] = lane_q[l][t][LANE_WIDTH-1:DATA_WIDTH];
                // Q rail from lane l + HALF_LANES
                data_q[l*SAMPLES_PER_LANE + t] =
                    lane_q[l+HALF_LANES][t][DATA_WIDTH-1:0];
                info_q[l*SAMPLES_PER_LANE + t] =
                    lane_q[l+HALF_LANES][t][LANE_WIDTH-1:DATA_WIDTH];
            end
        end
    end

endmodule

// ==== design/tap_ctrl_decode.sv ====
`timescale 1ns/10ps

module tap_ctrl_decode
    import adc_sample_pkg::*;
    import adc_tap_pkg::*;
#(
    parameter int   NUM_LANES = 4,                       // Even lane count
    localparam int  NUM_BITS  = NUM_LANES * LANE_WIDTH   // One load strobe per lane bit
)
(
    input  logic                      sys_clk,
    input  logic                      rst,

    input  tap_t                      dly_val,         // Tap to load
    input  bit_sel_t                  dly_sel,         // Which lane bit takes it
    input  logic                      phase_step_req,  // Level request from software
    input  logic                      phase_dir,       // Step direction, high is increment

    output logic [NUM_BITS-1:0]       bit_load,        // Registered one-hot load strobes
    output tap_t [NUM_LANES-1:0]      tap_value,       // Tap copy per lane
    output logic                      phase_step,      // Single-cycle step pulse
    output logic                      phase_dir_out
);

    logic req_seen;  // Request already stepped on, cleared when request drops

    // --------------------
    // Delay-load decode
    // --------------------
    // Bit k of the strobe vector is lane k/LANE_WIDTH, bit k%LANE_WIDTH
    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            bit_load <= '0;
        end
        else
        begin
            for (int k = 0; k < NUM_BITS; k++)
            begin
                bit_load[k] <= (int'(dly_sel) == k);  // Out-of-range code hits nothing
            end
        end
    end

    // --------------------
    // Tap fanout
    // --------------------
    // One flop set per lane keeps the load net local to each lane's delays
    always_ff @(posedge sys_clk)
    begin
        for (int l = 0; l < NUM_LANES; l++)
        begin
            tap_value[l] <= dly_val;
        end
    end

    // --------------------
    // Phase step
    // --------------------
    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            req_seen      <= 1'b0;
            phase_step    <= 1'b0;
            phase_dir_out <= 1'b0;
        end
        else
        begin
            phase_step    <= phase_step_req && !req_seen;  // Fire on first high sample only
            req_seen      <= phase_step_req;               // Re-arm once request goes low
            phase_dir_out <= phase_dir;                    // Aligned with the step pulse
        end
    end

endmodule

// ==== test/adc_capture_assertions.sv ====
`timescale 1ns/10ps

module adc_capture_assertions
    import adc_sample_pkg::*;
    import adc_tap_pkg::*;
#(
    parameter int   NUM_LANES  = 4,
    localparam int  NUM_BITS   = NUM_LANES * LANE_WIDTH,
    localparam int  HALF_LANES = NUM_LANES / 2,
    localparam int  IQ_SAMPLES = HALF_LANES * SAMPLES_PER_LANE
)
(
    input logic                                             sys_clk,
    input logic                                             rst,
    input tap_t                                             dly_val,
    input bit_sel_t                                         dly_sel,
    input logic                                             phase_step_req,
    input logic                                             phase_dir,
    input logic [NUM_BITS-1:0]                              bit_load,
    input tap_t [NUM_LANES-1:0]                             tap_value,
    input logic                                             phase_step,
    input logic                                             phase_dir_out,
    input lane_word_t [NUM_LANES-1:0][SAMPLES_PER_LANE-1:0] lane_data,
    input logic                                             lane_valid,
    input logic                                             lane_sync,
    input sample_data_t [IQ_SAMPLES-1:0]                    data_i,
    input sample_info_t [IQ_SAMPLES-1:0]                    info_i,
    input sample_data_t [IQ_SAMPLES-1:0]                    data_q,
    input sample_info_t [IQ_SAMPLES-1:0]                    info_q,
    input logic                                             sample_valid,
    input logic                                             sample_sync
);

    typedef lane_word_t [NUM_LANES-1:0][SAMPLES_PER_LANE-1:0] lane_set_t;
    typedef sample_data_t [IQ_SAMPLES-1:0] data_rail_t;
    typedef sample_info_t [IQ_SAMPLES-1:0] info_rail_t;

    int fail_count = 0;  // Read by the testbench after each phase

    // --------------------
    // Expected values
    // --------------------
    // One-hot strobe at the code, nothing past the last lane bit
    function automatic logic [NUM_BITS-1:0] expect_load(input bit_sel_t sel);
        logic [NUM_BITS-1:0] v;
        v = '0;
        if (int'(sel) < NUM_BITS)
        begin
            v[sel] = 1'b1;
        end
        return v;
    endfunction

    // Rail index n comes from lane first_lane + n/4, time slot n%4
    function automatic data_rail_t expect_data(input lane_set_t words, input int first_lane);
        data_rail_t r;
        for (int n = 0; n < IQ_SAMPLES; n++)
        begin
            r[n] = words[first_lane + n / SAMPLES_PER_LANE][n % SAMPLES_PER_LANE][11:0];
        end
        return r;
    endfunction

    function automatic info_rail_t expect_info(input lane_set_t words, input int first_lane);
        info_rail_t r;
        for (int n = 0; n < IQ_SAMPLES; n++)
        begin
            r[n] = words[first_lane + n / SAMPLES_PER_LANE][n % SAMPLES_PER_LANE][13:12];
        end
        return r;
    endfunction

    // --------------------
    // Control side
    // --------------------
    a_reset_state: assert property (@(posedge sys_clk)
        $past(rst) && !rst |-> bit_load == '0 && !phase_step && !sample_valid && !sample_sync)
    else
    begin
        fail_count++;
        $error(
            "Error at %0t: bit_load/phase_step/sample_valid/sample_sync = %h/%b/%b/%b, expected 0",
            $time, $sampled(bit_load), $sampled(phase_step),
            $sampled(sample_valid), $sampled(sample_sync));
    end

    a_bit_load: assert property (@(posedge sys_clk) disable iff (rst)
        !$past(rst) |-> bit_load == expect_load($past(dly_sel)))
    else
    begin
        fail_count++;
        $error("Error at %0t: bit_load = %h, expected %h", $time,
               $sampled(bit_load), expect_load($past(dly_sel)));
    end

    a_tap_fanout: assert property (@(posedge sys_clk) disable iff (rst)
        !$past(rst) |-> tap_value == {NUM_LANES{$past(dly_val)}})
    else
    begin
        fail_count++;
        $error("Error at %0t: tap_value = %h, expected %h", $time,
               $sampled(tap_value), {NUM_LANES{$past(dly_val)}});
    end

    // Arm is clear when the request was low or the decoder was in reset one edge before
    a_step_rise: assert property (@(posedge sys_clk) disable iff (rst)
        !$past(rst) |-> phase_step == ($past(phase_step_req)
                                       && ($past(rst, 2) || !$past(phase_step_req, 2))))
    else
    begin
        fail_count++;
        $error("Error at %0t: phase_step = %b, expected %b", $time, $sampled(phase_step),
               $past(phase_step_req) && ($past(rst, 2) || !$past(phase_step_req, 2)));
    end

    a_step_single: assert property (@(posedge sys_clk) disable iff (rst)
        phase_step |=> !phase_step)
    else
    begin
        fail_count++;
        $error("Phase step pulse lasted two cycles, seen at %0t", $time);
    end

    a_phase_dir: assert property (@(posedge sys_clk) disable iff (rst)
        !$past(rst) |-> phase_dir_out == $past(phase_dir))
    else
    begin
        fail_count++;
        $error("Error at %0t: phase_dir_out = %b, expected %b", $time,
               $sampled(phase_dir_out), $past(phase_dir));
    end

    // --------------------
    // Sample side
    // --------------------
    a_i_rail: assert property (@(posedge sys_clk) disable iff (rst)
        !$past(rst) |-> data_i == expect_data($past(lane_data), 0)
                        && info_i == expect_info($past(lane_data), 0))
    else
    begin
        fail_count++;
        $error("Error at %0t: data_i = %h, expected %h; info_i = %h, expected %h", $time,
               $sampled(data_i), expect_data($past(lane_data), 0),
               $sampled(info_i), expect_info($past(lane_data), 0));
    end

    a_q_rail: assert property (@(posedge sys_clk) disable iff (rst)
        !$past(rst) |-> data_q == expect_data($past(lane_data), HALF_LANES)
                        && info_q == expect_info($past(lane_data), HALF_LANES))
    else
    begin
        fail_count++;
        $error("Error at %0t: data_q = %h, expected %h; info_q = %h, expected %h", $time,
               $sampled(data_q), expect_data($past(lane_data), HALF_LANES),
               $sampled(info_q), expect_info($past(lane_data), HALF_LANES));
    end

    a_strobes: assert property (@(posedge sys_clk) disable iff (rst)
        !$past(rst) |-> sample_valid == $past(lane_valid) && sample_sync == $past(lane_sync))
    else
    begin
        fail_count++;
        $error("Error at %0t: sample_valid/sample_sync = %b/%b, expected %b/%b", $time,
               $sampled(sample_valid), $sampled(sample_sync),
               $past(lane_valid), $past(lane_sync));
    end

endmodule

// ==== test/adc_capture_tb.sv ====
`timescale 1ns/10ps

module adc_capture_tb
    import adc_sample_pkg::*;
    import adc_tap_pkg::*;
();

    localparam int NUM_LANES  = 4;
    localparam int NUM_BITS   = NUM_LANES * LANE_WIDTH;
    localparam int IQ_SAMPLES = (NUM_LANES / 2) * SAMPLES_PER_LANE;

    // --------------------
    // Phase lengths
    // --------------------
    localparam int RESET_CYCLES  = 10;
    localparam int SETTLE_CYCLES = 3;                  // Idle so the last checks land
    localparam int SWEEP_CODES   = 1 << SEL_WIDTH;     // Every select code once
    localparam int RANDOM_CODES  = 64;
    localparam int STEP_REQS     = 40;
    localparam int STEP_MAX_LEN  = 6 + 4;              // Longest hold plus longest gap
    localparam int SAMPLE_CYCLES = 200;
    localparam int NUM_PHASES    = 4;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + SWEEP_CODES + RANDOM_CODES
                                 + STEP_REQS * STEP_MAX_LEN + SAMPLE_CYCLES
                                 + NUM_PHASES * SETTLE_CYCLES + 50;

    logic                                             sys_clk = 1'b0;
    logic                                             rst;
    tap_t                                             dly_val;
    bit_sel_t                                         dly_sel;
    logic                                             phase_step_req;
    logic                                             phase_dir;
    logic [NUM_BITS-1:0]                              bit_load;
    tap_t [NUM_LANES-1:0]                             tap_value;
    logic                                             phase_step;
    logic                                             phase_dir_out;
    lane_word_t [NUM_LANES-1:0][SAMPLES_PER_LANE-1:0] lane_data;
    logic                                             lane_valid;
    logic                                             lane_sync;
    sample_data_t [IQ_SAMPLES-1:0]                    data_i;
    sample_info_t [IQ_SAMPLES-1:0]                    info_i;
    sample_data_t [IQ_SAMPLES-1:0]                    data_q;
    sample_info_t [IQ_SAMPLES-1:0]                    info_q;
    logic                                             sample_valid;
    logic                                             sample_sync;

    logic [31:0] rng = 32'h2fe284ff;  // xorshift state
    int cycle_count = 0;
    int phases_passed = 0;
    int phases_failed = 0;
    int fails_before = 0;             // Assertion failures before the current phase

    always #4 sys_clk = ~sys_clk;     // 8 ns period

    adc_capture_top #(
        .NUM_LANES      (NUM_LANES)
    ) adc_capture_top_i (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .dly_val        (dly_val),
        .dly_sel        (dly_sel),
        .phase_step_req (phase_step_req),
        .phase_dir      (phase_dir),
        .bit_load       (bit_load),
        .tap_value      (tap_value),
        .phase_step     (phase_step),
        .phase_dir_out  (phase_dir_out),
        .lane_data      (lane_data),
        .lane_valid     (lane_valid),
        .lane_sync      (lane_sync),
        .data_i         (data_i),
        .info_i         (info_i),
        .data_q         (data_q),
        .info_q         (info_q),
        .sample_valid   (sample_valid),
        .sample_sync    (sample_sync)
    );

    // Checkers ride on every instance of the top level
    bind adc_capture_top adc_capture_assertions #(
        .NUM_LANES      (NUM_LANES)
    ) adc_capture_assertions_i (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .dly_val        (dly_val),
        .dly_sel        (dly_sel),
        .phase_step_req (phase_step_req),
        .phase_dir      (phase_dir),
        .bit_load       (bit_load),
        .tap_value      (tap_value),
        .phase_step     (phase_step),
        .phase_dir_out  (phase_dir_out),
        .lane_data      (lane_data),
        .lane_valid     (lane_valid),
        .lane_sync      (lane_sync),
        .data_i         (data_i),
        .info_i         (info_i),
        .data_q         (data_q),
        .info_q         (info_q),
        .sample_valid   (sample_valid),
        .sample_sync    (sample_sync)
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    task automatic next_cycle();
        @(posedge sys_clk);
        #1;  // Inputs change away from the sampling edge
    endtask

    // Let the last checks of a phase land, then report its failures
    task automatic finish_phase(input string name);
        int new_fails;
        repeat (SETTLE_CYCLES) next_cycle();
        new_fails = adc_capture_top_i.adc_capture_assertions_i.fail_count - fails_before;
        fails_before = adc_capture_top_i.adc_capture_assertions_i.fail_count;
        if (new_fails == 0)
        begin
            phases_passed++;
            $display("Phase %s: ok", name);
        end
        else
        begin
            phases_failed++;
            $display("Phase %s: %0d assertion failures", name, new_fails);
        end
    endtask

    task automatic drive_lanes();
        logic [31:0] r;
        for (int l = 0; l < NUM_LANES; l++)
        begin
            for (int t = 0; t < SAMPLES_PER_LANE; t++)
            begin
                next_random(r);
                lane_data[l][t] = lane_word_t'(r);  // All 14 bits random
            end
        end
        next_random(r);
        lane_valid = r[3];
        lane_sync  = r[17] & r[29];  // Sync is rarer than valid
    endtask

    // --------------------
    // Timeout
    // --------------------
    always @(posedge sys_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial
    begin
        logic [31:0] r;
        int hold;
        int gap;

        rst            = 1'b1;
        dly_val        = '0;
        dly_sel        = '0;
        phase_step_req = 1'b0;
        phase_dir      = 1'b0;
        lane_data      = '0;
        lane_valid     = 1'b1;  // Strobes busy during reset, outputs must still clear
        lane_sync      = 1'b1;

        repeat (RESET_CYCLES - 1) next_cycle();
        phase_step_req = 1'b1;  // Request rising inside reset must not step
        next_cycle();
        rst            = 1'b0;
        phase_step_req = 1'b0;
        lane_valid     = 1'b0;
        lane_sync      = 1'b0;
        finish_phase("reset state");

        // Full sweep then random codes, covering the dead codes 56..63
        for (int code = 0; code < SWEEP_CODES + RANDOM_CODES; code++)
        begin
            next_random(r);
            dly_sel = (code < SWEEP_CODES) ? bit_sel_t'(code) : bit_sel_t'(r);
            dly_val = tap_t'(r >> 11);
            next_cycle();
        end
        finish_phase("delay load and tap fanout");

        for (int n = 0; n < STEP_REQS; n++)
        begin
            next_random(r);
            hold = 1 + int'(r[7:0]) % 6;
            gap  = 1 + int'(r[15:8]) % 4;
            phase_step_req = 1'b1;
            repeat (hold)
            begin
                next_random(r);
                phase_dir = r[9];  // Direction toggles freely
                next_cycle();
            end
            phase_step_req = 1'b0;
            repeat (gap) next_cycle();
        end
        finish_phase("phase step");

        repeat (SAMPLE_CYCLES)
        begin
            drive_lanes();
            next_cycle();
        end
        finish_phase("sample mapping and strobes");

        $display("Summary: %0d phases passed, %0d phases failed, %0d assertion failures",
                 phases_passed, phases_failed, fails_before);
        if (phases_failed == 0 && fails_before == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
